// ==== hdl/apb_regs.sv ====
// #########################################################################
// APB register block
// Control, window length, status with sticky flags, and build config
// #########################################################################

`timescale 1ns/10ps
`default_nettype none

module apb_regs
	import corr_pkg::*;
(
	input  logic intclk,
	input  logic rst,
	input  apb_req_t apb_in,
	output apb_rsp_t apb_out,
	input  frame_word_t frame_number,
	input  logic overflow_any,
	input  logic frame_dropped,
	output logic run,
	output sample_t invert_mask,
	output logic [15:0] integ_len
);

	logic access;
	logic wr_en;
	logic wr_status;
	logic ovf_sticky;
	logic drop_sticky;

	assign access = apb_in.psel && apb_in.penable;
	assign wr_en = access && apb_in.pwrite;
	assign wr_status = wr_en && (apb_in.paddr == REG_STATUS);

	always_ff @(posedge intclk) begin
		if (rst) begin
			run <= 1'b0;
			invert_mask <= '0;
			integ_len <= '0;
			ovf_sticky <= 1'b0;
			drop_sticky <= 1'b0;
		end else begin
			if (wr_en && apb_in.paddr == REG_CTRL) begin
				run <= apb_in.pwdata[CTRL_RUN];
				invert_mask <= apb_in.pwdata[CTRL_INV_LSB +: NUM_INPUTS];
			end
			if (wr_en && apb_in.paddr == REG_INTEG_LEN)
				integ_len <= apb_in.pwdata[15:0];
			// A new event wins over a clear in the same cycle
			ovf_sticky <= (ovf_sticky & ~(wr_status & apb_in.pwdata[STATUS_OVF])) | overflow_any;
			drop_sticky <= (drop_sticky & ~(wr_status & apb_in.pwdata[STATUS_DROP]))
				| frame_dropped;
		end
	end

	always_comb begin
		apb_out.prdata = '0;
		apb_out.pready = 1'b1; // No wait states
		apb_out.pslverr = 1'b0;
		case (apb_in.paddr)
			REG_CTRL: begin
				apb_out.prdata[CTRL_RUN] = run;
				apb_out.prdata[CTRL_INV_LSB +: NUM_INPUTS] = invert_mask;
			end
			REG_INTEG_LEN: apb_out.prdata[15:0] = integ_len;
			REG_STATUS: begin
				apb_out.prdata[15:0] = frame_number;
				apb_out.prdata[STATUS_OVF] = ovf_sticky;
				apb_out.prdata[STATUS_DROP] = drop_sticky;
			end
			REG_CONFIG: begin
				apb_out.prdata = CONFIG_WORD;
				apb_out.pslverr = wr_en; // Read-only
			end
			default: apb_out.pslverr = access;
		endcase
	end

	a_apb_setup: assert property (@(posedge intclk) disable iff (rst)
		apb_in.penable |-> $past(apb_in.psel));

endmodule

`default_nettype wire

// ==== hdl/coincidence_counter.sv ====
// #########################################################################
// Coincidence counter
// Counts cycles where both taps are high, saturating at full scale
// #########################################################################

`timescale 1ns/10ps
`default_nettype none

module coincidence_counter
	import corr_pkg::*;
(
	input  logic intclk,
	input  logic rst,
	input  logic en,
	input  logic load,
	input  logic tap_a,
	input  logic tap_b,
	output count_t count,
	output logic saturated
);

	logic hit;

	assign hit = tap_a & tap_b;

	always_ff @(posedge intclk) begin
		if (rst) begin
			count <= '0;
			saturated <= 1'b0;
		end else if (en) begin
			if (load) begin
				count <= {{(RESOLUTION-1){1'b0}}, hit}; // First sample of a window
				saturated <= 1'b0;
			end else if (hit) begin
				if (count == COUNT_MAX)
					saturated <= 1'b1; // Increment lost, count stays at full scale
				else
					count <= count + 1'b1;
			end
		end
	end

	a_monotonic: assert property (@(posedge intclk) disable iff (rst)
		!(en && load) |=> count >= $past(count));

endmodule

`default_nettype wire

// ==== hdl/corr_pkg.sv ====
// #########################################################################
// Correlator package
// Sizes, frame layout, register constants and the shared struct types
// #########################################################################

`default_nettype none

package corr_pkg;

`include "corr_regmap.svh"

	localparam int NUM_INPUTS = 4;
	localparam int LAG_AUTO = 4; // Lags 1 to LAG_AUTO
	localparam int LAG_CROSS = 2;
	localparam int CROSS_LAGS = 2*LAG_CROSS - 1; // Lags -1, 0 and +1
	localparam int NUM_BASELINES = NUM_INPUTS*(NUM_INPUTS-1)/2;
	localparam int HIST_DEPTH = LAG_AUTO + 1;
	localparam int RESOLUTION = 12;
	localparam int WORD_WIDTH = 16;

	// Counter order matches the frame, one word per counter after the header
	localparam int NUM_AUTOS = NUM_INPUTS*LAG_AUTO;
	localparam int NUM_CROSSES = NUM_BASELINES*CROSS_LAGS;
	localparam int NUM_COUNTERS = NUM_INPUTS + NUM_AUTOS + NUM_CROSSES;
	localparam int AUTO_BASE = NUM_INPUTS;
	localparam int CROSS_BASE = NUM_INPUTS + NUM_AUTOS;
	localparam int FRAME_WORDS = 1 + NUM_COUNTERS;
	localparam int FRAME_IDX_W = $clog2(FRAME_WORDS);

	localparam logic [3:0] REG_CTRL = `CORR_REG_CTRL;
	localparam logic [3:0] REG_INTEG_LEN = `CORR_REG_INTEG_LEN;
	localparam logic [3:0] REG_STATUS = `CORR_REG_STATUS;
	localparam logic [3:0] REG_CONFIG = `CORR_REG_CONFIG;
	localparam int CTRL_RUN = `CORR_CTRL_RUN_BIT;
	localparam int CTRL_INV_LSB = `CORR_CTRL_INV_LSB;
	localparam int STATUS_OVF = `CORR_STATUS_OVF_BIT;
	localparam int STATUS_DROP = `CORR_STATUS_DROP_BIT;
	localparam logic [31:0] CONFIG_WORD = {8'(RESOLUTION), 8'(LAG_CROSS),
		8'(LAG_AUTO), 8'(NUM_INPUTS)};

	typedef logic [RESOLUTION-1:0] count_t;
	typedef logic [WORD_WIDTH-1:0] frame_word_t;
	typedef logic [NUM_INPUTS-1:0] sample_t;

	localparam count_t COUNT_MAX = '1;

	typedef struct packed {
		count_t [NUM_INPUTS-1:0] pulses;
		count_t [NUM_AUTOS-1:0] autos; // Input-major, lag ascending
		count_t [NUM_CROSSES-1:0] crosses; // Baseline-major, lag -1, 0, +1
		logic [NUM_COUNTERS-1:0] overflow;
	} corr_counts_t;

	typedef struct packed {
		logic [3:0] paddr;
		logic psel;
		logic penable;
		logic pwrite;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic pready;
		logic pslverr;
	} apb_rsp_t;

	// Pairs run (0,1), (0,2), (0,3), (1,2), (1,3), (2,3)
	function automatic int baseline_index(input int a, input int b);
		return a*(2*NUM_INPUTS - a - 1)/2 + (b - a - 1);
	endfunction

endpackage

`default_nettype wire

// ==== hdl/correlator_array.sv ====
// #########################################################################
// Correlator array
// Inverts the lines, keeps their history and runs the pulse, auto and
// cross coincidence counters off the history taps
// #########################################################################

`timescale 1ns/10ps
`default_nettype none

module correlator_array
	import corr_pkg::*;
(
	input  logic intclk,
	input  logic rst,
	input  logic count_en,
	input  logic window_start,
	input  sample_t line_in,
	input  sample_t invert_mask,
	output wire corr_counts_t counts
);

	sample_t sample;
	sample_t [HIST_DEPTH-1:0] history;
	logic en_q;
	logic load_q;

	assign sample = line_in ^ invert_mask;

	delay_line u_hist (
		.intclk(intclk),
		.rst(rst),
		.sample(sample),
		.history(history)
	);

	// Enables trail by one cycle so they line up with tap 0
	always_ff @(posedge intclk) begin
		if (rst) begin
			en_q <= 1'b0;
			load_q <= 1'b0;
		end else begin
			en_q <= count_en;
			load_q <= window_start;
		end
	end

	// #########################################################################
	// Pulse and auto counters
	// #########################################################################
	for (genvar i = 0; i < NUM_INPUTS; i++) begin : g_input
		coincidence_counter u_pulse (
			.intclk(intclk), .rst(rst), .en(en_q), .load(load_q),
			.tap_a(history[0][i]), .tap_b(history[0][i]),
			.count(counts.pulses[i]), .saturated(counts.overflow[i])
		);
		for (genvar k = 1; k <= LAG_AUTO; k++) begin : g_auto
			coincidence_counter u_auto (
				.intclk(intclk), .rst(rst), .en(en_q), .load(load_q),
				.tap_a(history[0][i]), .tap_b(history[k][i]),
				.count(counts.autos[i*LAG_AUTO + k - 1]),
				.saturated(counts.overflow[AUTO_BASE + i*LAG_AUTO + k - 1])
			);
		end
	end

	// #########################################################################
	// Cross counters, j = 0 is lag -1
	// #########################################################################
	for (genvar a = 0; a < NUM_INPUTS; a++) begin : g_cross_a
		for (genvar b = a + 1; b < NUM_INPUTS; b++) begin : g_cross_b
			for (genvar j = 0; j < CROSS_LAGS; j++) begin : g_lag
				// Negative lags delay input a, positive lags delay input b
				coincidence_counter u_cross (
					.intclk(intclk), .rst(rst), .en(en_q), .load(load_q),
					.tap_a(history[(j < LAG_CROSS-1) ? (LAG_CROSS-1-j) : 0][a]),
					.tap_b(history[(j > LAG_CROSS-1) ? (j-LAG_CROSS+1) : 0][b]),
					.count(counts.crosses[baseline_index(a, b)*CROSS_LAGS + j]),
					.saturated(counts.overflow[CROSS_BASE + baseline_index(a, b)*CROSS_LAGS + j])
				);
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/correlator_top.sv ====
// #########################################################################
// Photon coincidence correlator
// APB control, window timing, counter array and frame stream output
// #########################################################################

`timescale 1ns/10ps
`default_nettype none

module correlator_top
	import corr_pkg::*;
(
	input  logic intclk,
	input  logic rst,
	input  apb_req_t apb_in,
	output apb_rsp_t apb_out,
	input  sample_t line_in,
	output frame_word_t frame_word,
	output logic frame_valid,
	input  logic frame_ready,
	output logic window_active
);

	logic run;
	sample_t invert_mask;
	logic [15:0] integ_len;
	logic count_en;
	logic window_start;
	logic window_done;
	frame_word_t frame_number;
	corr_counts_t counts;
	logic frame_dropped;
	logic overflow_any;

	apb_regs u_regs (
		.intclk(intclk), .rst(rst), .apb_in(apb_in), .apb_out(apb_out),
		.frame_number(frame_number), .overflow_any(overflow_any),
		.frame_dropped(frame_dropped), .run(run), .invert_mask(invert_mask),
		.integ_len(integ_len)
	);

	integration_timer u_timer (
		.intclk(intclk), .rst(rst), .run(run), .integ_len(integ_len),
		.count_en(count_en), .window_start(window_start), .window_done(window_done),
		.window_active(window_active), .frame_number(frame_number)
	);

	correlator_array u_array (
		.intclk(intclk), .rst(rst), .count_en(count_en), .window_start(window_start),
		.line_in(line_in), .invert_mask(invert_mask), .counts(counts)
	);

	frame_serializer u_ser (
		.intclk(intclk), .rst(rst), .window_done(window_done), .counts(counts),
		.frame_number(frame_number), .frame_ready(frame_ready),
		.frame_word(frame_word), .frame_valid(frame_valid),
		.frame_dropped(frame_dropped), .overflow_any(overflow_any)
	);

endmodule

`default_nettype wire

// ==== hdl/delay_line.sv ====
// #########################################################################
// Sample history
// Shift register of past samples from every line, deep enough for the
// longest lag
// #########################################################################

`timescale 1ns/10ps
`default_nettype none

module delay_line
	import corr_pkg::*;
(
	input  logic intclk,
	input  logic rst,
	input  sample_t sample,
	output sample_t [HIST_DEPTH-1:0] history
);

	// History survives between windows so lags reach back across the gap
	always_ff @(posedge intclk) begin
		if (rst) begin
			history <= '0;
		end else begin
			history <= {history[HIST_DEPTH-2:0], sample}; // Newest sample in tap 0
		end
	end

endmodule

`default_nettype wire

// ==== hdl/frame_serializer.sv ====
// #########################################################################
// Frame serializer
// Snapshots the counts after each window and streams them as 16-bit
// words under valid/ready, dropping a snapshot while a frame is pending
// #########################################################################

`timescale 1ns/10ps
`default_nettype none

module frame_serializer
	import corr_pkg::*;
(
	input  logic intclk,
	input  logic rst,
	input  logic window_done,
	input  corr_counts_t counts,
	input  frame_word_t frame_number,
	input  logic frame_ready,
	output frame_word_t frame_word,
	output logic frame_valid,
	output logic frame_dropped,
	output logic overflow_any
);

	frame_word_t [FRAME_WORDS-1:0] words_in;
	frame_word_t [FRAME_WORDS-1:0] snap;
	logic [FRAME_IDX_W-1:0] word_idx;
	logic done_q;
	logic last_beat;
	logic busy;
	logic take;

	always_comb begin
		words_in[0] = frame_number;
		for (int i = 0; i < NUM_INPUTS; i++)
			words_in[1 + i] = frame_word_t'(counts.pulses[i]);
		for (int i = 0; i < NUM_AUTOS; i++)
			words_in[1 + AUTO_BASE + i] = frame_word_t'(counts.autos[i]);
		for (int i = 0; i < NUM_CROSSES; i++)
			words_in[1 + CROSS_BASE + i] = frame_word_t'(counts.crosses[i]);
	end

	assign overflow_any = |counts.overflow;

	// A frame ending on this edge frees the slot for the next snapshot
	assign last_beat = frame_valid && frame_ready
		&& (word_idx == FRAME_IDX_W'(FRAME_WORDS - 1));
	assign busy = frame_valid && !last_beat;
	assign take = done_q && !busy;
	assign frame_dropped = done_q && busy;
	assign frame_word = snap[word_idx];

	always_ff @(posedge intclk) begin
		if (rst) begin
			done_q <= 1'b0;
			frame_valid <= 1'b0;
			word_idx <= '0;
		end else begin
			done_q <= window_done; // Last counted sample lands one cycle after window_done
			if (take) begin
				frame_valid <= 1'b1;
				word_idx <= '0;
			end else if (last_beat) begin
				frame_valid <= 1'b0;
				word_idx <= '0;
			end else if (frame_valid && frame_ready) begin
				word_idx <= word_idx + 1'b1;
			end
		end
	end

	always_ff @(posedge intclk) begin
		if (take)
			snap <= words_in;
	end

	a_hold: assert property (@(posedge intclk) disable iff (rst)
		frame_valid && !frame_ready |=> frame_valid && $stable(frame_word));

endmodule

`default_nettype wire

// ==== hdl/integration_timer.sv ====
// #########################################################################
// Integration timer
// Runs windows of integ_len counted cycles with a one-cycle gap between
// them, and numbers the completed windows
// #########################################################################

`timescale 1ns/10ps
`default_nettype none

module integration_timer
	import corr_pkg::*;
(
	input  logic intclk,
	input  logic rst,
	input  logic run,
	input  logic [15:0] integ_len,
	output logic count_en,
	output logic window_start,
	output logic window_done,
	output logic window_active,
	output frame_word_t frame_number
);

	typedef enum logic [1:0] {IDLE, ACTIVE, GAP} state_t;

	state_t state;
	logic [15:0] cycle_cnt;
	logic [15:0] last_cycle;

	assign last_cycle = (integ_len == 16'd0) ? 16'd0 : integ_len - 16'd1; // Zero runs as one

	always_ff @(posedge intclk) begin
		if (rst) begin
			state <= IDLE;
			cycle_cnt <= '0;
			frame_number <= '0;
		end else begin
			case (state)
				IDLE: if (run) state <= ACTIVE;
				ACTIVE: begin
					// Dropping run closes the window early
					if (!run || cycle_cnt >= last_cycle) begin
						state <= GAP;
						cycle_cnt <= '0;
						frame_number <= frame_number + 1'b1;
					end else begin
						cycle_cnt <= cycle_cnt + 1'b1;
					end
				end
				GAP: state <= run ? ACTIVE : IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	assign window_active = (state == ACTIVE);
	assign count_en = window_active; // Every active cycle is counted
	assign window_start = window_active && (cycle_cnt == 16'd0);
	assign window_done = (state == GAP);

	// A window that runs on starts right after its single gap cycle
	a_gap_restart: assert property (@(posedge intclk) disable iff (rst)
		window_done && run |=> window_start && !window_done);

endmodule

`default_nettype wire

// ==== include/corr_regmap.svh ====
// #########################################################################
// Correlator register map
// APB offsets and bit positions of the control and status registers
// #########################################################################

`ifndef CORR_REGMAP_SVH
`define CORR_REGMAP_SVH

`define CORR_REG_CTRL        4'h0
`define CORR_REG_INTEG_LEN   4'h4
`define CORR_REG_STATUS      4'h8
`define CORR_REG_CONFIG      4'hC

`define CORR_CTRL_RUN_BIT    0
`define CORR_CTRL_INV_LSB    4
`define CORR_STATUS_OVF_BIT  16
`define CORR_STATUS_DROP_BIT 17

`endif

// ==== list.f ====
+incdir+include
hdl/corr_pkg.sv
hdl/delay_line.sv
hdl/coincidence_counter.sv
hdl/correlator_array.sv
hdl/integration_timer.sv
hdl/apb_regs.sv
hdl/frame_serializer.sv
hdl/correlator_top.sv
verification/tb_correlator.sv

// ==== verification/tb_correlator.sv ====
// #########################################################################
// Correlator testbench
// Drives APB, pulse lines and frame back-pressure, models the counts from
// the recorded samples and compares every received frame word
// #########################################################################

`timescale 1ns/10ps
`default_nettype none

`include "corr_regmap.svh"

module tb_correlator
	import corr_pkg::*;
();

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 16;
	localparam int COUNT_LIMIT = (1 << RESOLUTION) - 1;
	localparam int WINDOW_CYCLES = 4*101 + 4*101 + 6*201 + 2*5001 + 101;
	localparam int DRAIN_CYCLES = 20*2*FRAME_WORDS + 250;
	localparam longint WATCHDOG_NS =
		2*(RESET_CYCLES + WINDOW_CYCLES + DRAIN_CYCLES)*CLK_PERIOD;

	logic intclk = 1'b0;
	logic rst;
	apb_req_t apb_in;
	apb_rsp_t apb_out;
	sample_t line_in;
	frame_word_t frame_word;
	logic frame_valid;
	logic frame_ready;
	logic window_active;

	int seed = 32'h2f3d7356;
	int line_mode = 2; // 0 random, 1 all ones, 2 all zeros
	int ready_mode = 0; // 0 high, 1 low, 2 random
	sample_t cur_mask = '0;
	sample_t samples[$];
	int win_first[$];
	int win_last[$];
	int win_count = 0;
	bit prev_active = 1'b0;
	frame_word_t rx_words[FRAME_WORDS];
	int rx_idx = 0;
	int rx_count = 0;
	int rx_hdr[$];
	int last_hdr = 0;
	int total_drops = 0;
	int base;

	correlator_top dut0 (
		.intclk(intclk), .rst(rst), .apb_in(apb_in), .apb_out(apb_out),
		.line_in(line_in), .frame_word(frame_word), .frame_valid(frame_valid),
		.frame_ready(frame_ready), .window_active(window_active)
	);

	always #(CLK_PERIOD/2) intclk = ~intclk;

	// #########################################################################
	// Reporting and compare tasks
	// #########################################################################
	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_word(input string name, input frame_word_t exp, input frame_word_t act);
		if (act !== exp)
			fail_run($sformatf("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act));
	endtask

	task automatic check_apb(input string name, input apb_rsp_t exp, input apb_rsp_t act,
			input bit cmp_data);
		if (act.pready !== exp.pready || act.pslverr !== exp.pslverr
				|| (cmp_data && act.prdata !== exp.prdata))
			fail_run($sformatf("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act));
	endtask

	// Window hdr must last len cycles and the next one must follow after one gap cycle
	task automatic check_window(input int hdr, input int len);
		int got;
		got = win_last[hdr-1] - win_first[hdr-1] + 1;
		if (got != len)
			fail_run($sformatf("Error at %0t ns: window_active expected %0d cycles, got %0d",
				$time, len, got));
		if (win_first.size() <= hdr || win_first[hdr] != win_last[hdr-1] + 2)
			fail_run("Window did not restart after a single gap cycle");
	endtask

	// #########################################################################
	// Reference model
	// #########################################################################
	function automatic bit sample_bit(input int t, input int i);
		if (t < 0)
			return 1'b0; // History is zero before the first edge after reset
		return samples[t][i];
	endfunction

	function automatic frame_word_t expected_word(input int w, input int idx);
		int cnt;
		int a;
		int b;
		int k;
		int d;
		int n;
		bit hit;
		cnt = 0;
		if (idx <= NUM_INPUTS) begin
			a = idx - 1;
			b = a;
			d = 0;
		end else if (idx <= NUM_INPUTS + NUM_INPUTS*LAG_AUTO) begin
			k = idx - 1 - NUM_INPUTS;
			a = k / LAG_AUTO;
			b = a;
			d = k % LAG_AUTO + 1;
		end else begin
			k = idx - 1 - NUM_INPUTS - NUM_INPUTS*LAG_AUTO;
			d = k % 3 - 1;
			n = 0;
			for (int i = 0; i < NUM_INPUTS; i++) begin
				for (int j = i + 1; j < NUM_INPUTS; j++) begin
					if (n == k / 3) begin
						a = i;
						b = j;
					end
					n++;
				end
			end
		end
		for (int t = win_first[w-1]; t <= win_last[w-1]; t++) begin
			if (d >= 0)
				hit = sample_bit(t, a) & sample_bit(t - d, b);
			else
				hit = sample_bit(t - 1, a) & sample_bit(t, b); // Input a leads by one sample
			if (hit && cnt < COUNT_LIMIT)
				cnt++;
		end
		return frame_word_t'(cnt);
	endfunction

	function automatic logic [31:0] status_value(input bit drop, input bit ovf);
		return (32'(drop) << `CORR_STATUS_DROP_BIT) | (32'(ovf) << `CORR_STATUS_OVF_BIT)
			| 32'(win_count[15:0]);
	endfunction

	// Records every sample as the DUT sees it after inversion
	always @(posedge intclk) begin
		if (!rst) begin
			samples.push_back(line_in ^ cur_mask);
			if (window_active && !prev_active)
				win_first.push_back(samples.size() - 1);
			if (!window_active && prev_active) begin
				win_last.push_back(samples.size() - 2);
				win_count++;
			end
			prev_active = window_active;
		end
	end

	task automatic compare_frame();
		int hdr;
		hdr = rx_words[0];
		if (hdr == 0 || hdr > win_count || hdr <= last_hdr)
			fail_run($sformatf("Frame header %0d does not follow a completed window", hdr));
		for (int i = 1; i < FRAME_WORDS; i++)
			check_word($sformatf("frame_word[%0d]", i), expected_word(hdr, i), rx_words[i]);
		rx_hdr.push_back(hdr);
		last_hdr = hdr;
		rx_count++;
	endtask

	always @(posedge intclk) begin
		if (!rst && frame_valid && frame_ready) begin
			rx_words[rx_idx] = frame_word;
			if (rx_idx == FRAME_WORDS - 1) begin
				compare_frame();
				rx_idx = 0;
			end else begin
				rx_idx++;
			end
		end
	end

	// #########################################################################
	// Stimulus
	// #########################################################################
	always @(negedge intclk) begin
		case (line_mode)
			0: line_in = sample_t'($random(seed));
			1: line_in = '1;
			default: line_in = '0;
		endcase
		case (ready_mode)
			0: frame_ready = 1'b1;
			1: frame_ready = 1'b0;
			default: frame_ready = (($random(seed) & 3) != 0);
		endcase
	end

	task automatic apb_transfer(input logic [3:0] addr, input bit write, input logic [31:0] wdata,
			input logic [31:0] exp_rdata, input bit exp_err, input bit cmp_data, input string what);
		apb_rsp_t rsp;
		apb_rsp_t exp;
		@(negedge intclk);
		apb_in.paddr = addr;
		apb_in.psel = 1'b1;
		apb_in.penable = 1'b0;
		apb_in.pwrite = write;
		apb_in.pwdata = wdata;
		@(negedge intclk);
		apb_in.penable = 1'b1;
		@(posedge intclk);
		while (!apb_out.pready)
			@(posedge intclk);
		rsp = apb_out;
		@(negedge intclk);
		apb_in = '0;
		if (write && addr == `CORR_REG_CTRL)
			cur_mask = wdata[`CORR_CTRL_INV_LSB +: NUM_INPUTS];
		exp.prdata = exp_rdata;
		exp.pready = 1'b1;
		exp.pslverr = exp_err;
		check_apb($sformatf("apb_out (%s)", what), exp, rsp, cmp_data);
	endtask

	task automatic start_run(input int len, input sample_t mask);
		apb_transfer(`CORR_REG_INTEG_LEN, 1, len, 0, 0, 0, "INTEG_LEN write");
		apb_transfer(`CORR_REG_CTRL, 1, (32'(mask) << `CORR_CTRL_INV_LSB) | 1, 0, 0, 0,
			"CTRL write");
	endtask

	task automatic stop_and_drain();
		apb_transfer(`CORR_REG_CTRL, 1, 32'(cur_mask) << `CORR_CTRL_INV_LSB, 0, 0, 0, "CTRL write");
		repeat (4) @(posedge intclk);
		while (rx_count != win_count - total_drops)
			@(posedge intclk);
	endtask

	task automatic wait_frames(input int target);
		while (rx_count < target)
			@(posedge intclk);
	endtask

	initial begin
		#(WATCHDOG_NS);
		fail_run("Watchdog expired before all tests finished");
	end

	initial begin
		rst = 1'b1;
		apb_in = '0;
		line_in = '0;
		frame_ready = 1'b1;
		repeat (RESET_CYCLES) @(negedge intclk);
		rst = 1'b0;

		// Build configuration, error responses and reset values
		apb_transfer(`CORR_REG_CONFIG, 0, 0, {8'd12, 8'd2, 8'd4, 8'd4}, 0, 1, "CONFIG read");
		apb_transfer(`CORR_REG_CONFIG, 1, 32'h1234, 0, 1, 0, "CONFIG write");
		apb_transfer(4'h2, 0, 0, 0, 1, 0, "unmapped read");
		apb_transfer(`CORR_REG_CTRL, 0, 0, 0, 0, 1, "CTRL read");
		apb_transfer(`CORR_REG_STATUS, 0, 0, 0, 0, 1, "STATUS read");

		// Random pulses, plain and inverted
		line_mode = 0;
		for (int pass = 0; pass < 2; pass++) begin
			base = rx_count;
			start_run(100, (pass == 0) ? 4'b0000 : 4'b0101);
			wait_frames(base + 3);
			for (int i = 0; i < 3; i++)
				check_window(rx_hdr[base+i], 100);
			for (int i = 1; i < 3; i++)
				check_word("frame header", rx_hdr[base+i-1] + 1, rx_hdr[base+i]);
			stop_and_drain();
		end

		// Back-pressure drops the second snapshot
		ready_mode = 1;
		start_run(200, 4'b0000);
		do @(posedge intclk); while (!frame_valid);
		repeat (250) @(posedge intclk);
		base = rx_count;
		ready_mode = 2;
		wait_frames(base + 2);
		check_word("frame header", rx_hdr[base] + 2, rx_hdr[base+1]);
		total_drops = 1;
		stop_and_drain();
		ready_mode = 0;
		apb_transfer(`CORR_REG_STATUS, 0, 0, status_value(1, 0), 0, 1, "STATUS read");
		apb_transfer(`CORR_REG_STATUS, 1, 32'(1) << `CORR_STATUS_DROP_BIT, 0, 0, 0,
			"STATUS write");
		apb_transfer(`CORR_REG_STATUS, 0, 0, status_value(0, 0), 0, 1, "STATUS read");

		// Saturation with every line held high
		line_mode = 1;
		base = rx_count;
		start_run(5000, 4'b0000);
		wait_frames(base + 1);
		for (int i = 1; i < FRAME_WORDS; i++)
			check_word($sformatf("frame_word[%0d]", i), frame_word_t'(COUNT_LIMIT), rx_words[i]);
		stop_and_drain();
		apb_transfer(`CORR_REG_STATUS, 0, 0, status_value(0, 1), 0, 1, "STATUS read");
		apb_transfer(`CORR_REG_STATUS, 1, 32'(1) << `CORR_STATUS_OVF_BIT, 0, 0, 0,
			"STATUS write");
		apb_transfer(`CORR_REG_STATUS, 0, 0, status_value(0, 0), 0, 1, "STATUS read");

		// Run cleared in the middle of a window
		line_mode = 0;
		start_run(100, 4'b0000);
		do @(posedge intclk); while (!window_active);
		repeat (37) @(posedge intclk);
		stop_and_drain();
		if (win_last[win_count-1] - win_first[win_count-1] + 1 >= 100) begin
			fail_run("Clearing run did not end the window early");
		end else begin
			$display("Regression passed");
			$finish;
		end
	end

endmodule

`default_nettype wire
